// File: vlog.f
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_slot_if.sv
hdl/inst_predecode.sv
hdl/inst_pick.sv
hdl/fetch_hold.sv
hdl/fetch_ctrl.sv
hdl/fetch_top.sv
sim/fetch_checker.sv
sim/tb_fetch.sv

// File: Bender.yml
package:
  name: fetch_unit

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/fetch_slot_if.sv
      - hdl/inst_predecode.sv
      - hdl/inst_pick.sv
      - hdl/fetch_hold.sv
      - hdl/fetch_ctrl.sv
      - hdl/fetch_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/fetch_checker.sv
      - sim/tb_fetch.sv

// File: sim/tb_fetch.sv
`default_nettype none

`include "fetch_config.svh"

module tb_fetch;

    localparam int ROWS = 24;
    localparam int LIMIT = ROWS * 12 + 40;

    logic                     i_clk;
    logic                     i_rst_n;
    logic                     o_imem_ren;
    logic [`FETCH_ADDR_W-1:0] o_imem_raddr;
    logic                     i_imem_valid;
    logic [`FETCH_WORD_W-1:0] i_imem_rdata;
    logic                     i_branch_valid;
    logic [`FETCH_ADDR_W-1:0] i_branch_target;
    logic                     i_output_ready;
    logic                     o_output_valid;
    logic [`FETCH_INST_W-1:0] o_inst0;
    logic [`FETCH_INST_W-1:0] o_inst1;
    logic [1:0]               o_compressed;
    logic                     o_count;

    // stimulus table columns are word, latency, not-ready cycles, transfer flag and target
    logic [`FETCH_WORD_W-1:0] t_word [0:ROWS-1];
    int                       t_lat [0:ROWS-1];
    int                       t_gap [0:ROWS-1];
    logic                     t_xfer [0:ROWS-1];
    logic [`FETCH_ADDR_W-1:0] t_target [0:ROWS-1];

    integer seed;
    int     n_rows = 0;
    int     cycles = 0;
    logic   req_flag = 0;

    fetch_top UUT (.*);

    fetch_checker #(.N_ROWS(ROWS)) u_check (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_imem_ren(o_imem_ren),
        .i_imem_raddr(o_imem_raddr), .i_imem_valid(i_imem_valid),
        .i_branch_valid(i_branch_valid), .i_output_ready(i_output_ready),
        .i_output_valid(o_output_valid), .i_inst0(o_inst0), .i_inst1(o_inst1),
        .i_compressed(o_compressed), .i_count(o_count)
    );

    initial begin
        i_clk = 0;
        forever #10 i_clk = ~i_clk;
    end

    // a request is taken on the edge that ends the cycle it is seen in
    always @(negedge i_clk) begin
        if (i_rst_n && o_imem_ren)
            req_flag = 1;
    end

    // run limit sized from the table length
    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout at cycle %0d, %0d/%0d pairs sent, %0d mismatches, %0d failures",
                     cycles, u_check.sends, ROWS, u_check.mismatches, u_check.failures);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task add_row(input logic [63:0] word, input int lat, input int gap, input logic xfer,
                 input logic [`FETCH_ADDR_W-1:0] target);
        t_word[n_rows]   = word;
        t_lat[n_rows]    = lat;
        t_gap[n_rows]    = gap;
        t_xfer[n_rows]   = xfer;
        t_target[n_rows] = target;
        n_rows++;
    endtask

    task load_table();
        // two 32-bit, compressed pairs and the mixed orders
        add_row(64'h00100093_00000013, 1, 0, 0, 39'h0);
        add_row(64'h1234_5678_0505_4501, 2, 1, 0, 39'h0);
        add_row(64'hABCD_0010_0093_0001, 1, 2, 0, 39'h0);
        add_row(64'h0000_4501_0000_0013, 3, 0, 0, 39'h0);
        // jal and branch in slot 0, jalr in slot 1
        add_row(64'h00000013_008000EF, 1, 0, 1, 39'h00_0000_1000);
        add_row(64'h00100093_00B50463, 2, 1, 1, 39'h00_0000_2040);
        add_row(64'h00008067_00000013, 1, 2, 1, 39'h00_0000_3080);
        // c.j, c.beqz and c.jr in slot 0
        add_row(64'h0000_0000_0505_A001, 3, 0, 1, 39'h00_0000_40c2);
        add_row(64'h0000_0000_0001_C001, 1, 1, 1, 39'h12_3456_7890);
        add_row(64'h0000_0000_0001_8082, 2, 0, 1, 39'h7f_ffff_fff0);
        // c.mv is no jump
        add_row(64'h0000_0000_0505_852A, 1, 0, 0, 39'h0);
        add_row(64'h0000_0000_A001_0001, 1, 2, 1, 39'h00_0001_0000);
        add_row(64'h0000_8082_0000_0013, 3, 1, 1, 39'h00_0002_0004);
        add_row(64'h00000013_00100093, 1, 0, 0, 39'h0);
        add_row(64'hFFFF_0001_0001_0001, 1, 0, 0, 39'h0);
        add_row(64'h0000_0010_0093_0505, 2, 2, 0, 39'h0);
        add_row(64'h00000013_00000013, 1, 0, 0, 39'h0);
        add_row(64'h0000_C001_0010_0093, 2, 0, 1, 39'h40_0000_0100);
        add_row(64'h4501_0505_0001_0505, 1, 1, 0, 39'h0);
        add_row(64'h00000013_00008067, 3, 2, 1, 39'h00_0000_0202);
        add_row(64'h00100093_00100093, 1, 0, 0, 39'h0);
        add_row(64'h0000_0000_4501_0001, 1, 1, 0, 39'h0);
        add_row(64'h1111_0001_0010_0093, 2, 0, 0, 39'h0);
        add_row(64'h00000013_00000013, 1, 0, 0, 39'h0);
    endtask

    task wait_request();
        while (!req_flag) begin
            @(posedge i_clk);
            #2;
        end
        req_flag = 0;
    endtask

    // strobe the word in, then hold ready low for the gap
    task present_word(input int i);
        int k;
        repeat (t_lat[i] - 1) begin
            @(posedge i_clk);
            #2;
        end
        k = t_gap[i] + ($unsigned($random(seed)) % 2);
        i_imem_valid   = 1;
        i_imem_rdata   = t_word[i];
        i_output_ready = (k == 0);
        while (k > 0) begin
            @(posedge i_clk);
            #2;
            // junk on the bus proves the pair comes from the hold buffer
            i_imem_valid   = 0;
            i_imem_rdata   = {$random(seed), $random(seed)};
            k--;
            i_output_ready = (k == 0);
        end
        @(posedge i_clk);
        #2;
        i_imem_valid   = 0;
        i_output_ready = 0;
    endtask

    task supply_target(input int i);
        repeat ($unsigned($random(seed)) % 3) begin
            @(posedge i_clk);
            #2;
        end
        i_branch_valid  = 1;
        i_branch_target = t_target[i];
        @(posedge i_clk);
        #2;
        i_branch_valid = 0;
    endtask

    initial begin
        seed            = 32'h3fae_4a1f;
        i_rst_n         = 0;
        i_imem_valid    = 0;
        i_imem_rdata    = '0;
        i_branch_valid  = 0;
        i_branch_target = '0;
        i_output_ready  = 0;
        load_table();
        for (int i = 0; i < ROWS; i++)
            u_check.set_row(i, t_word[i], t_target[i]);
        repeat (10) @(posedge i_clk);
        #2;
        i_rst_n = 1;
        for (int i = 0; i < ROWS; i++) begin
            wait_request();
            present_word(i);
            if (t_xfer[i])
                supply_target(i);
        end
        repeat (4) @(posedge i_clk);
        u_check.final_check();
        $display("errors: %0d mismatches, %0d other failures", u_check.mismatches,
                 u_check.failures);
        if (u_check.mismatches + u_check.failures == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/fetch_checker.sv
`default_nettype none

`include "fetch_config.svh"

module fetch_checker #(
    parameter int N_ROWS = 24,
    parameter logic [`FETCH_ADDR_W-1:0] RESET_ADDR = `FETCH_RESET_ADDR
) (
    input wire                     i_clk,
    input wire                     i_rst_n,
    input wire                     i_imem_ren,
    input wire [`FETCH_ADDR_W-1:0] i_imem_raddr,
    input wire                     i_imem_valid,
    input wire                     i_branch_valid,
    input wire                     i_output_ready,
    input wire                     i_output_valid,
    input wire [`FETCH_INST_W-1:0] i_inst0,
    input wire [`FETCH_INST_W-1:0] i_inst1,
    input wire [1:0]               i_compressed,
    input wire                     i_count
);

    // rows handed over by the testbench
    logic [`FETCH_WORD_W-1:0] row_word [0:N_ROWS-1];
    logic [`FETCH_ADDR_W-1:0] row_target [0:N_ROWS-1];

    int mismatches = 0;
    int failures = 0;
    int sends = 0;

    // model of the fetch unit
    logic [`FETCH_ADDR_W-1:0] exp_pc;
    logic [`FETCH_ADDR_W-1:0] pend_target;
    logic                     outstanding;
    logic                     wait_br;
    logic                     holding;
    logic                     stall;
    logic [`FETCH_WORD_W-1:0] w;
    logic [31:0]              e_inst0;
    logic [31:0]              e_inst1;
    logic [1:0]               e_comp;
    logic [1:0]               e_br;
    logic [3:0]               e_adv;
    logic [31:0]              last_inst0;
    logic [31:0]              last_inst1;
    logic [1:0]               last_comp;
    logic                     last_count;

    task set_row(input int idx, input logic [`FETCH_WORD_W-1:0] word,
                 input logic [`FETCH_ADDR_W-1:0] target);
        row_word[idx]   = word;
        row_target[idx] = target;
    endtask

    task check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task report_fail(input string what);
        failures++;
        $display("failure at %0t: %s", $time, what);
    endtask

    // jump or branch test straight from the isa encodings
    function automatic logic is_transfer(input logic [31:0] inst, input logic comp);
        logic [2:0] f3;
        f3 = inst[15:13];
        if (!comp)
            return (inst[6:0] == 7'h6f) || (inst[6:0] == 7'h67) || (inst[6:0] == 7'h63);
        if (inst[1:0] == 2'b01)
            return (f3 == 3'd1) || (f3 == 3'd5) || (f3 == 3'd6) || (f3 == 3'd7);
        if (inst[1:0] == 2'b10)
            return (f3 == 3'd4) && (inst[11:7] != 5'd0) && (inst[6:2] == 5'd0);
        return 1'b0;
    endfunction

    // every row must have been sent by the end of the run
    task final_check();
        if (sends != N_ROWS)
            report_fail($sformatf("only %0d of %0d pairs were sent", sends, N_ROWS));
    endtask

    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            check_val("o_imem_ren", 0, i_imem_ren);
            check_val("o_output_valid", 0, i_output_valid);
            exp_pc      = RESET_ADDR;
            outstanding = 0;
            wait_br     = 0;
            holding     = 0;
        end else begin
            // redirect lands with the strobe
            if (wait_br && i_branch_valid) begin
                exp_pc  = pend_target;
                wait_br = 0;
            end
            // address stays put until the answer lands
            if (outstanding && !i_imem_valid)
                check_val("o_imem_raddr", exp_pc, i_imem_raddr);
            if (i_imem_valid)
                outstanding = 0;
            stall = i_output_valid && !i_output_ready;
            if (i_output_valid && sends >= N_ROWS) begin
                report_fail("pair offered after the last table row");
            end else if (i_output_valid) begin
                // split and predecode the row word
                w          = row_word[sends];
                e_comp[0]  = (w[1:0] != 2'b11);
                e_inst0    = w[31:0];
                e_inst1    = e_comp[0] ? w[47:16] : w[63:32];
                e_comp[1]  = (e_inst1[1:0] != 2'b11);
                e_br[0]    = is_transfer(e_inst0, e_comp[0]);
                e_br[1]    = is_transfer(e_inst1, e_comp[1]);
                if (e_br[0])
                    e_adv = e_comp[0] ? 4'd2 : 4'd4;
                else
                    e_adv = 4'd8 - 4'd2 * (4'(e_comp[0]) + 4'(e_comp[1]));
                check_val("o_inst0", e_inst0, i_inst0);
                check_val("o_inst1", e_inst1, i_inst1);
                check_val("o_compressed", e_comp, i_compressed);
                check_val("o_count", !e_br[0], i_count);
                // held pair may not move under back-pressure
                if (holding) begin
                    check_val("o_inst0 (held)", last_inst0, i_inst0);
                    check_val("o_inst1 (held)", last_inst1, i_inst1);
                    check_val("o_compressed (held)", last_comp, i_compressed);
                    check_val("o_count (held)", last_count, i_count);
                end
                if (i_output_ready) begin
                    exp_pc = exp_pc + `FETCH_ADDR_W'(e_adv);
                    if (e_br != 2'b00) begin
                        wait_br     = 1;
                        pend_target = row_target[sends];
                    end
                    sends++;
                    holding = 0;
                end else begin
                    holding    = 1;
                    last_inst0 = i_inst0;
                    last_inst1 = i_inst1;
                    last_comp  = i_compressed;
                    last_count = i_count;
                end
            end
            if (i_imem_ren) begin
                if (outstanding)
                    report_fail("request issued while another one is outstanding");
                if (wait_br)
                    report_fail("request issued before the branch target arrived");
                if (stall)
                    report_fail("request issued while a pair is held");
                check_val("o_imem_raddr", exp_pc, i_imem_raddr);
                outstanding = 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/fetch_top.sv
`default_nettype none

`include "fetch_config.svh"

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_ADDR = `FETCH_RESET_ADDR
) (
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    // instruction memory request and strobed answer
    output logic                  o_imem_ren,
    output fetch_pkg::addr_t      o_imem_raddr,
    input  wire                   i_imem_valid,
    input  wire fetch_pkg::word_t i_imem_rdata,
    // resolved target from the back end
    input  wire                   i_branch_valid,
    input  wire fetch_pkg::addr_t i_branch_target,
    // pair handed to decode
    input  wire                   i_output_ready,
    output logic                  o_output_valid,
    output fetch_pkg::inst_t      o_inst0,
    output fetch_pkg::inst_t      o_inst1,
    output logic [1:0]            o_compressed,
    output logic                  o_count
);

    fetch_slot_if slot ();

    // high while an unaccepted pair sits in the hold buffer
    logic hold;

    // size detection, split and predecode of the raw word
    inst_pick u_pick (
        .i_imem_rdata (i_imem_rdata),
        .slot         (slot.src)
    );

    // back-pressure buffer and output select
    fetch_hold u_hold (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_imem_valid (i_imem_valid),
        .i_hold       (hold),
        .slot         (slot.hold),
        .o_inst0      (o_inst0),
        .o_inst1      (o_inst1),
        .o_compressed (o_compressed),
        .o_count      (o_count)
    );

    // fsm and pc
    fetch_ctrl #(
        .RESET_ADDR (RESET_ADDR)
    ) u_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_imem_valid    (i_imem_valid),
        .i_output_ready  (i_output_ready),
        .i_branch_valid  (i_branch_valid),
        .i_branch_target (i_branch_target),
        .slot            (slot.ctrl),
        .o_imem_ren      (o_imem_ren),
        .o_imem_raddr    (o_imem_raddr),
        .o_output_valid  (o_output_valid),
        .o_hold          (hold)
    );

endmodule

`default_nettype wire

// File: hdl/fetch_ctrl.sv
`default_nettype none

`include "fetch_config.svh"

module fetch_ctrl #(
    parameter fetch_pkg::addr_t RESET_ADDR = `FETCH_RESET_ADDR
) (
    input  wire                   i_clk,
    input  wire                   i_rst_n,
    input  wire                   i_imem_valid,
    input  wire                   i_output_ready,
    input  wire                   i_branch_valid,
    input  wire fetch_pkg::addr_t i_branch_target,
    fetch_slot_if.ctrl            slot,
    output logic                  o_imem_ren,
    output fetch_pkg::addr_t      o_imem_raddr,
    output logic                  o_output_valid,
    output logic                  o_hold
);
    import fetch_pkg::*;

    fetch_state_e state;
    fetch_state_e next_state;
    addr_t        pc;
    addr_t        next_pc;
    logic         init_done;
    logic [1:0]   held_compressed;
    logic [1:0]   held_branch;
    logic [1:0]   compressed;
    logic [1:0]   branch;
    logic         hold;
    logic         output_valid;
    logic         sent;
    logic         branched;
    logic [3:0]   len0;
    logic [3:0]   len1;
    logic [3:0]   advance;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= ST_INIT;
            pc        <= RESET_ADDR;
            init_done <= 1'b0;
        end else begin
            state     <= next_state;
            pc        <= next_pc;
            init_done <= 1'b1;
        end
    end

    // the memory word may change once its strobe is gone
    // keep the bits that steer the pc for a stalled pair
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            held_compressed <= 2'b00;
            held_branch     <= 2'b00;
        end else if (i_imem_valid) begin
            held_compressed <= slot.compressed;
            held_branch     <= slot.branch;
        end
    end

    assign hold       = (state == ST_VALID);
    assign compressed = hold ? held_compressed : slot.compressed;
    assign branch     = hold ? held_branch : slot.branch;

    // pair offered on the response itself or out of the hold buffer
    assign output_valid = i_imem_valid || hold;
    assign sent         = output_valid && i_output_ready;
    assign branched     = (branch != 2'b00);

    always_comb begin
        next_state = state;
        case (state)
            // first request goes out once reset has settled
            ST_INIT: next_state = init_done ? ST_FETCH : ST_INIT;
            ST_FETCH,
            ST_CACHE,
            ST_VALID: begin
                if (sent)
                    next_state = branched ? ST_RESOL : ST_FETCH;
                else if (output_valid)
                    next_state = ST_VALID;
                else
                    next_state = ST_CACHE;
            end
            // no fetch past a transfer until the target arrives
            ST_RESOL: next_state = i_branch_valid ? ST_FETCH : ST_RESOL;
            default:  next_state = ST_INIT;
        endcase
    end

    // byte size of each slot
    assign len0 = compressed[0] ? 4'(`FETCH_LEN_C) : 4'(`FETCH_LEN_I);
    assign len1 = compressed[1] ? 4'(`FETCH_LEN_C) : 4'(`FETCH_LEN_I);

    // a transfer in slot 0 ends the pair after that slot
    assign advance = branch[0] ? len0 : (len0 + len1);

    always_comb begin
        next_pc = pc;
        if (state == ST_RESOL) begin
            if (i_branch_valid)
                next_pc = i_branch_target;
        end else if (sent) begin
            next_pc = pc + addr_t'(advance);
        end
    end

    // the request leaves with the address the pc moves to on this edge
    // and stays equal to the pc until the answer comes back
    assign o_imem_ren     = (next_state == ST_FETCH);
    assign o_imem_raddr   = next_pc;
    assign o_output_valid = output_valid;
    assign o_hold         = hold;

endmodule

`default_nettype wire

// File: hdl/fetch_hold.sv
`default_nettype none

module fetch_hold (
    input  wire              i_clk,
    input  wire              i_rst_n,
    input  wire              i_imem_valid,
    input  wire              i_hold,
    fetch_slot_if.hold       slot,
    output fetch_pkg::inst_t o_inst0,
    output fetch_pkg::inst_t o_inst1,
    output logic [1:0]       o_compressed,
    output logic             o_count
);
    import fetch_pkg::*;

    inst_t      hold_inst0;
    inst_t      hold_inst1;
    logic [1:0] hold_compressed;
    logic       hold_count;
    logic       live_count;

    // second slot only counts when the first one does not redirect
    assign live_count = !slot.branch[0];

    // instruction payload
    always_ff @(posedge i_clk) begin
        if (i_imem_valid) begin
            hold_inst0 <= slot.inst0;
            hold_inst1 <= slot.inst1;
        end
    end

    // size and count bits
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hold_compressed <= 2'b00;
            hold_count      <= 1'b0;
        end else if (i_imem_valid) begin
            hold_compressed <= slot.compressed;
            hold_count      <= live_count;
        end
    end

    // live pair on the response cycle
    // registered pair while decode stalls us
    assign o_inst0      = i_hold ? hold_inst0 : slot.inst0;
    assign o_inst1      = i_hold ? hold_inst1 : slot.inst1;
    assign o_compressed = i_hold ? hold_compressed : slot.compressed;
    assign o_count      = i_hold ? hold_count : live_count;

endmodule

`default_nettype wire

// File: hdl/inst_pick.sv
`default_nettype none

module inst_pick (
    input  wire fetch_pkg::word_t i_imem_rdata,
    fetch_slot_if.src             slot
);
    import fetch_pkg::*;

    inst_t      inst0;
    inst_t      inst1;
    logic [1:0] compressed;
    logic [1:0] branch;

    // any low bit pattern other than 11 marks a 16-bit instruction
    assign compressed[0] = (i_imem_rdata[1:0] != 2'b11);

    // slot 0 always starts at the bottom of the word
    assign inst0 = i_imem_rdata[31:0];

    // slot 1 starts right after slot 0 ends
    // when slot 0 is compressed the upper 16 bits of the word go unused
    assign inst1 = compressed[0] ? i_imem_rdata[47:16] : i_imem_rdata[63:32];

    // slot 1 size comes from its own low bits
    assign compressed[1] = (inst1[1:0] != 2'b11);

    // one predecoder per slot
    inst_predecode u_predecode0 (
        .i_inst       (inst0),
        .i_compressed (compressed[0]),
        .o_branch     (branch[0])
    );

    inst_predecode u_predecode1 (
        .i_inst       (inst1),
        .i_compressed (compressed[1]),
        .o_branch     (branch[1])
    );

    // slot 1 is still presented after a slot 0 transfer
    // downstream uses the count to ignore it
    assign slot.inst0      = inst0;
    assign slot.inst1      = inst1;
    assign slot.compressed = compressed;
    assign slot.branch     = branch;

endmodule

`default_nettype wire

// File: hdl/inst_predecode.sv
`default_nettype none

module inst_predecode (
    input  wire fetch_pkg::inst_t i_inst,
    input  wire                   i_compressed,
    output logic                  o_branch
);
    import fetch_pkg::*;

    opcode_e    opcode;
    logic [1:0] quadrant;
    logic [2:0] funct3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic       branch_32;
    logic       branch_16;

    // fields of the 32-bit encoding
    assign opcode = opcode_e'(i_inst[6:0]);

    // fields of the 16-bit encoding
    assign quadrant = i_inst[1:0];
    assign funct3   = i_inst[15:13];
    assign rs1      = i_inst[11:7];
    assign rs2      = i_inst[6:2];

    // jal, jalr and conditional branches
    always_comb begin
        case (opcode)
            OP_JAL,
            OP_JALR,
            OP_BRANCH: branch_32 = 1'b1;
            default:   branch_32 = 1'b0;
        endcase
    end

    always_comb begin
        branch_16 = 1'b0;
        case (quadrant)
            // c.jal, c.j, c.beqz and c.bnez
            2'b01: begin
                branch_16 = (funct3 == 3'b001) || (funct3 == 3'b101) ||
                            (funct3[2:1] == 2'b11);
            end
            // c.jr and c.jalr need a source register and no rs2
            // rs2 nonzero would be c.mv or c.add
            2'b10: begin
                branch_16 = (funct3 == 3'b100) && (rs1 != 5'd0) && (rs2 == 5'd0);
            end
            default: begin
                branch_16 = 1'b0;
            end
        endcase
    end

    assign o_branch = i_compressed ? branch_16 : branch_32;

endmodule

`default_nettype wire

// File: hdl/fetch_slot_if.sv
`default_nettype none

interface fetch_slot_if;
    import fetch_pkg::*;

    // split instructions, low slot first
    inst_t      inst0;
    inst_t      inst1;
    // bit 0 belongs to slot 0
    logic [1:0] compressed;
    // set when the slot holds a jump or branch
    logic [1:0] branch;

    // produced by the splitter
    modport src (
        output inst0,
        output inst1,
        output compressed,
        output branch
    );

    // hold buffer needs the whole pair
    modport hold (
        input inst0,
        input inst1,
        input compressed,
        input branch
    );

    // control only needs the sizes and transfer flags
    modport ctrl (
        input compressed,
        input branch
    );

endinterface

`default_nettype wire

// File: hdl/fetch_pkg.sv
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

    // instruction address, memory word and one instruction slot
    typedef logic [`FETCH_ADDR_W-1:0] addr_t;
    typedef logic [`FETCH_WORD_W-1:0] word_t;
    typedef logic [`FETCH_INST_W-1:0] inst_t;

    // fetch control states
    // fetch has a request in flight and forwards the response when it lands
    // cache waits on a slow memory answer
    // valid holds an unaccepted pair for decode
    // resol waits for the back end to supply the branch target
    // init issues the very first request
    typedef enum logic [2:0] {
        ST_FETCH = 3'h0,
        ST_CACHE = 3'h1,
        ST_VALID = 3'h2,
        ST_RESOL = 3'h3,
        ST_INIT  = 3'h4
    } fetch_state_e;

    // major opcodes of the 32-bit control transfers
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

endpackage

`default_nettype wire

// File: hdl/fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// instruction addresses live in the sv39 virtual space
`define FETCH_ADDR_W 39

// one memory beat holds up to two uncompressed instructions
`define FETCH_WORD_W 64

// each slot is wide enough for a full 32-bit instruction
// a compressed instruction uses only the low half
`define FETCH_INST_W 32

// pc loaded while reset is held
`define FETCH_RESET_ADDR 39'h40_0000_0000

// instruction sizes in bytes
// used to step the pc past what decode consumed
`define FETCH_LEN_C 2
`define FETCH_LEN_I 4

`endif
